//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_mmu
FILELIST  = project.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the simulation, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^No errors$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- mmu.sv
`timescale 1ns/1ns
`default_nettype none

module mmu(
	input  logic                 clk,
	input  logic                 rst,
	input  logic [7:0]           asid,
	input  logic                 is_user_mode,
	input  mmu_pkg::virt_t       inst_vaddr,
	input  mmu_pkg::virt_t       data_vaddr,

	output mmu_pkg::mmu_result_t inst_result,
	output mmu_pkg::mmu_result_t data_result,

	input  mmu_pkg::tlb_index_t  tlbrw_index,
	input  logic                 tlbrw_we,
	input  mmu_pkg::tlb_entry_t  tlbrw_wdata,
	output mmu_pkg::tlb_entry_t  tlbrw_rdata,

	input  mmu_pkg::uint32_t     tlbp_entry_hi,
	output mmu_pkg::uint32_t     tlbp_index
);
	import mmu_pkg::*;

	logic        inst_mapped;
	logic        data_mapped;
	tlb_result_t inst_tlb;
	tlb_result_t data_tlb;

	// kseg0 and kseg1 (100, 101) bypass the tlb.
	function automatic logic is_mapped(input virt_t vaddr);
		return ~vaddr[31] || (vaddr[31:30] == 2'b11);
	endfunction

	assign inst_mapped = is_mapped(inst_vaddr);
	assign data_mapped = is_mapped(data_vaddr);

	assign inst_result.phy_addr  = inst_mapped ? inst_tlb.phy_addr : {3'b000, inst_vaddr[28:0]};
	assign inst_result.virt_addr = inst_vaddr;
	assign inst_result.miss      = inst_mapped & inst_tlb.miss;
	assign inst_result.illegal   = is_user_mode & inst_vaddr[31];
	assign inst_result.invalid   = inst_mapped & ~inst_tlb.valid;
	assign inst_result.dirty     = 1'b0;

	assign data_result.phy_addr  = data_mapped ? data_tlb.phy_addr : {3'b000, data_vaddr[28:0]};
	assign data_result.virt_addr = data_vaddr;
	assign data_result.miss      = data_mapped & data_tlb.miss;
	assign data_result.illegal   = is_user_mode & data_vaddr[31];
	assign data_result.invalid   = data_mapped & ~data_tlb.valid;
	// unmapped segments are always writable.
	assign data_result.dirty     = ~data_mapped | data_tlb.dirty;

	tlb tlb_inst(
		.clk,
		.rst,
		.asid,
		.inst_vaddr,
		.data_vaddr,
		.inst_result(inst_tlb),
		.data_result(data_tlb),
		.tlbrw_index,
		.tlbrw_we,
		.tlbrw_wdata,
		.tlbrw_rdata,
		.tlbp_entry_hi,
		.tlbp_index
	);

endmodule

`default_nettype wire

//--- mmu_checker.sv
`timescale 1ns/1ns
`default_nettype none

module mmu_checker(
	input wire logic        clk,
	input wire logic        rst,
	input wire logic        is_user_mode,
	input wire logic [31:0] inst_vaddr,
	input wire logic [31:0] data_vaddr,
	input wire logic        inst_miss,
	input wire logic        data_miss,
	input wire logic        inst_illegal,
	input wire logic        data_illegal,
	input wire logic [31:0] tlbp_index
);
	import mmu_pkg::*;

	// kseg0 and kseg1 never reach the tlb.
	assert property (@(posedge clk) disable iff (rst)
		(inst_vaddr[31:30] == 2'b10) |-> !inst_miss)
		else $error("inst miss on an unmapped address");
	assert property (@(posedge clk) disable iff (rst)
		(data_vaddr[31:30] == 2'b10) |-> !data_miss)
		else $error("data miss on an unmapped address");

	assert property (@(posedge clk) disable iff (rst)
		(inst_illegal == (is_user_mode & inst_vaddr[31])) &&
		(data_illegal == (is_user_mode & data_vaddr[31])))
		else $error("illegal flag disagrees with mode and address");

	assert property (@(posedge clk) disable iff (rst)
		!tlbp_index[31] |-> (tlbp_index < TLB_ENTRIES))
		else $error("probe index out of range");

endmodule

bind mmu_top mmu_checker checker_inst(
	.clk(clk),
	.rst(rst),
	.is_user_mode(is_user_mode),
	.inst_vaddr(inst_vaddr),
	.data_vaddr(data_vaddr),
	.inst_miss(inst_miss),
	.data_miss(data_miss),
	.inst_illegal(inst_illegal),
	.data_illegal(data_illegal),
	.tlbp_index(tlbp_index)
);

`default_nettype wire

//--- mmu_pkg.sv
`default_nettype none

package mmu_pkg;

	// --------------------------------------------------
	// sizes.
	// --------------------------------------------------
	localparam int TLB_ENTRIES = 16;
	localparam int TLB_INDEX_W = 4;

	typedef logic [31:0] virt_t;
	typedef logic [31:0] phys_t;
	typedef logic [31:0] uint32_t;
	typedef logic [TLB_INDEX_W-1:0] tlb_index_t;

	// --------------------------------------------------
	// one entry maps an even/odd pair of 4 KB pages.
	// --------------------------------------------------
	typedef struct packed {
		logic [18:0] vpn2;
		logic [7:0]  asid;
		logic        g;
		logic [19:0] pfn0;
		logic        d0;
		logic        v0;
		logic [19:0] pfn1;
		logic        d1;
		logic        v1;
	} tlb_entry_t;

	localparam int TLB_ENTRY_W = $bits(tlb_entry_t);

	typedef struct packed {
		logic  miss;
		logic  valid;
		logic  dirty;
		phys_t phy_addr;
	} tlb_result_t;

	// dirty set means the page may be written.
	typedef struct packed {
		phys_t phy_addr;
		virt_t virt_addr;
		logic  miss;
		logic  illegal;
		logic  invalid;
		logic  dirty;
	} mmu_result_t;

endpackage

`default_nettype wire

//--- mmu_top.sv
`timescale 1ns/1ns
`default_nettype none

module mmu_top(
	input  logic                            clk,
	input  logic                            rst,
	input  logic [7:0]                      asid,
	input  logic                            is_user_mode,
	input  logic [31:0]                     inst_vaddr,
	input  logic [31:0]                     data_vaddr,

	output logic [31:0]                     inst_phy_addr,
	output logic [31:0]                     inst_virt_addr,
	output logic                            inst_miss,
	output logic                            inst_illegal,
	output logic                            inst_invalid,
	output logic                            inst_dirty,

	output logic [31:0]                     data_phy_addr,
	output logic [31:0]                     data_virt_addr,
	output logic                            data_miss,
	output logic                            data_illegal,
	output logic                            data_invalid,
	output logic                            data_dirty,

	input  logic [mmu_pkg::TLB_INDEX_W-1:0] tlbrw_index,
	input  logic                            tlbrw_we,
	input  logic [mmu_pkg::TLB_ENTRY_W-1:0] tlbrw_wdata,
	output logic [mmu_pkg::TLB_ENTRY_W-1:0] tlbrw_rdata,

	input  logic [31:0]                     tlbp_entry_hi,
	output logic [31:0]                     tlbp_index
);
	import mmu_pkg::*;

	mmu_result_t inst_result;
	mmu_result_t data_result;
	tlb_entry_t  rdata;

	// --------------------------------------------------
	// unpack results onto flat ports.
	// --------------------------------------------------
	assign inst_phy_addr  = inst_result.phy_addr;
	assign inst_virt_addr = inst_result.virt_addr;
	assign inst_miss      = inst_result.miss;
	assign inst_illegal   = inst_result.illegal;
	assign inst_invalid   = inst_result.invalid;
	assign inst_dirty     = inst_result.dirty;

	assign data_phy_addr  = data_result.phy_addr;
	assign data_virt_addr = data_result.virt_addr;
	assign data_miss      = data_result.miss;
	assign data_illegal   = data_result.illegal;
	assign data_invalid   = data_result.invalid;
	assign data_dirty     = data_result.dirty;

	assign tlbrw_rdata = rdata;

	mmu mmu_inst(
		.clk,
		.rst,
		.asid,
		.is_user_mode,
		.inst_vaddr,
		.data_vaddr,
		.inst_result,
		.data_result,
		.tlbrw_index,
		.tlbrw_we,
		.tlbrw_wdata(tlb_entry_t'(tlbrw_wdata)),
		.tlbrw_rdata(rdata),
		.tlbp_entry_hi,
		.tlbp_index
	);

endmodule

`default_nettype wire

//--- project.f
mmu_pkg.sv
tlb_lookup_if.sv
tlb_request_decode.sv
tlb_entry.sv
tlb_select.sv
tlb.sv
mmu.sv
mmu_top.sv
mmu_checker.sv
tb_mmu.sv

//--- tb_mmu.sv
`timescale 1ns/1ns
`default_nettype none

module tb_mmu;
	import mmu_pkg::*;

	localparam int MAX_CYCLES = 2000;

	logic                   clk;
	logic                   rst;
	logic [7:0]             asid;
	logic                   is_user_mode;
	logic [31:0]            inst_vaddr;
	logic [31:0]            data_vaddr;
	logic [31:0]            inst_phy_addr;
	logic [31:0]            inst_virt_addr;
	logic                   inst_miss;
	logic                   inst_illegal;
	logic                   inst_invalid;
	logic                   inst_dirty;
	logic [31:0]            data_phy_addr;
	logic [31:0]            data_virt_addr;
	logic                   data_miss;
	logic                   data_illegal;
	logic                   data_invalid;
	logic                   data_dirty;
	tlb_index_t             tlbrw_index;
	logic                   tlbrw_we;
	logic [TLB_ENTRY_W-1:0] tlbrw_wdata;
	logic [TLB_ENTRY_W-1:0] tlbrw_rdata;
	logic [31:0]            tlbp_entry_hi;
	logic [31:0]            tlbp_index;
	int                     checks;
	int                     errors;

	mmu_top UUT(.*);

	initial
	begin
		clk = 1'b0;
		forever
			#5 clk = ~clk;
	end

	initial
	begin
		repeat (MAX_CYCLES) @(posedge clk);
		$display("Timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
		$display("Errors found");
		$finish;
	end

	// --------------------------------------------------
	// helpers.
	// --------------------------------------------------
	function automatic logic [TLB_ENTRY_W-1:0] pack_entry(
		input logic [18:0] vpn2,
		input logic [7:0]  key,
		input logic        g,
		input logic [19:0] pfn0,
		input logic        d0,
		input logic        v0,
		input logic [19:0] pfn1,
		input logic        d1,
		input logic        v1
	);
		return {vpn2, key, g, pfn0, d0, v0, pfn1, d1, v1};
	endfunction

	task automatic bit_check(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("MISMATCH t=%0t %s: got %b expected %b", $time, name, got, exp);
		end
	endtask

	task automatic word_check(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("MISMATCH t=%0t %s: got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic entry_check(input string name, input logic [TLB_ENTRY_W-1:0] got,
		input logic [TLB_ENTRY_W-1:0] exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("MISMATCH t=%0t %s: got %h expected %h", $time, name, got, exp);
		end
	endtask

	// the entry is written on the second edge.
	task automatic write_entry(input tlb_index_t idx, input logic [TLB_ENTRY_W-1:0] e);
		@(posedge clk);
		tlbrw_index <= idx;
		tlbrw_wdata <= e;
		tlbrw_we    <= 1'b1;
		@(posedge clk);
		tlbrw_we    <= 1'b0;
	endtask

	task automatic drive_addrs(input logic user, input logic [31:0] iva,
		input logic [31:0] dva, input logic [7:0] key);
		@(posedge clk);
		is_user_mode <= user;
		inst_vaddr   <= iva;
		data_vaddr   <= dva;
		asid         <= key;
		@(negedge clk);
	endtask

	task automatic probe_key(input logic [31:0] entry_hi);
		@(posedge clk);
		tlbp_entry_hi <= entry_hi;
		@(negedge clk);
	endtask

	// --------------------------------------------------
	// tests.
	// --------------------------------------------------
	task automatic unmapped_segments();
		drive_addrs(1'b0, 32'h8012_3456, 32'hA0AB_CDEF, 8'h21);
		word_check("inst_phy_addr", inst_phy_addr, 32'h0012_3456);
		word_check("data_phy_addr", data_phy_addr, 32'h00AB_CDEF);
		word_check("inst_virt_addr", inst_virt_addr, 32'h8012_3456);
		word_check("data_virt_addr", data_virt_addr, 32'hA0AB_CDEF);
		bit_check("inst_miss", inst_miss, 1'b0);
		bit_check("data_miss", data_miss, 1'b0);
		bit_check("inst_invalid", inst_invalid, 1'b0);
		bit_check("data_invalid", data_invalid, 1'b0);
		bit_check("inst_dirty", inst_dirty, 1'b0);
		bit_check("data_dirty", data_dirty, 1'b1);
	endtask

	task automatic entry_readback();
		int                     idx [3] = '{3, 7, 15};
		logic [TLB_ENTRY_W-1:0] expected [3];
		for (int i = 0; i < TLB_ENTRIES; i++)
		begin
			@(posedge clk);
			tlbrw_index <= tlb_index_t'(i);
			@(negedge clk);
			entry_check("tlbrw_rdata", tlbrw_rdata, '0);
		end
		// vpn2 in kseg0 keeps these entries out of later lookups.
		for (int k = 0; k < 3; k++)
		begin
			expected[k] = {19'h40000 | 19'(idx[k]), $urandom, 21'($urandom)};
			write_entry(tlb_index_t'(idx[k]), expected[k]);
		end
		for (int k = 0; k < 3; k++)
		begin
			@(posedge clk);
			tlbrw_index <= tlb_index_t'(idx[k]);
			@(negedge clk);
			entry_check("tlbrw_rdata", tlbrw_rdata, expected[k]);
		end
	endtask

	task automatic mapped_hits();
		logic [19:0] pfn0;
		logic [19:0] pfn1;
		logic [11:0] off;
		pfn0 = 20'($urandom);
		pfn1 = 20'($urandom);
		off  = 12'($urandom);
		write_entry(4'd5, pack_entry(19'h00123, 8'h21, 1'b0, pfn0, 1'b1, 1'b1,
			pfn1, 1'b0, 1'b1));
		drive_addrs(1'b0, {19'h00123, 1'b0, off}, {19'h00123, 1'b1, off}, 8'h21);
		word_check("inst_phy_addr", inst_phy_addr, {pfn0, off});
		word_check("data_phy_addr", data_phy_addr, {pfn1, off});
		bit_check("inst_miss", inst_miss, 1'b0);
		bit_check("data_miss", data_miss, 1'b0);
		bit_check("inst_invalid", inst_invalid, 1'b0);
		bit_check("data_invalid", data_invalid, 1'b0);
		bit_check("inst_dirty", inst_dirty, 1'b0);
		bit_check("data_dirty", data_dirty, 1'b0);
		// kseg2 pair with an invalid even half and a writable odd half.
		write_entry(4'd9, pack_entry(19'h60010, 8'h21, 1'b0, pfn1, 1'b0, 1'b0,
			pfn0, 1'b1, 1'b1));
		drive_addrs(1'b0, {19'h60010, 1'b0, off}, {19'h60010, 1'b1, off}, 8'h21);
		word_check("inst_phy_addr", inst_phy_addr, {pfn1, off});
		bit_check("inst_invalid", inst_invalid, 1'b1);
		word_check("data_phy_addr", data_phy_addr, {pfn0, off});
		bit_check("data_miss", data_miss, 1'b0);
		bit_check("data_dirty", data_dirty, 1'b1);
	endtask

	task automatic miss_and_invalid();
		drive_addrs(1'b0, {19'h00123, 1'b0, 12'h010}, {19'h00123, 1'b1, 12'h020}, 8'h22);
		bit_check("inst_miss", inst_miss, 1'b1);
		bit_check("data_miss", data_miss, 1'b1);
		write_entry(4'd5, pack_entry(19'h00123, 8'h21, 1'b1, 20'h12345, 1'b0, 1'b1,
			20'h6789A, 1'b1, 1'b1));
		drive_addrs(1'b0, {19'h00123, 1'b0, 12'h010}, {19'h00123, 1'b1, 12'h020}, 8'h22);
		bit_check("inst_miss", inst_miss, 1'b0);
		word_check("inst_phy_addr", inst_phy_addr, 32'h1234_5010);
		word_check("data_phy_addr", data_phy_addr, 32'h6789_A020);
		write_entry(4'd6, pack_entry(19'h00200, 8'h21, 1'b0, 20'h00AAA, 1'b0, 1'b0,
			20'h00BBB, 1'b0, 1'b1));
		drive_addrs(1'b0, {19'h00200, 1'b0, 12'h004}, {19'h00200, 1'b1, 12'h008}, 8'h21);
		bit_check("inst_miss", inst_miss, 1'b0);
		bit_check("inst_invalid", inst_invalid, 1'b1);
		bit_check("data_invalid", data_invalid, 1'b0);
	endtask

	task automatic probe_lookup();
		write_entry(4'd12, pack_entry(19'h00300, 8'h21, 1'b0, 20'h1, 1'b0, 1'b1,
			20'h2, 1'b0, 1'b1));
		write_entry(4'd10, pack_entry(19'h00300, 8'h21, 1'b0, 20'h3, 1'b0, 1'b1,
			20'h4, 1'b0, 1'b1));
		probe_key({19'h00300, 5'b0, 8'h21});
		word_check("tlbp_index", tlbp_index, 32'd10);
		// index 5 is global, so any asid matches.
		probe_key({19'h00123, 5'b0, 8'h77});
		word_check("tlbp_index", tlbp_index, 32'd5);
		probe_key({19'h00777, 5'b0, 8'h21});
		word_check("tlbp_index", tlbp_index, 32'h8000_0000);
	endtask

	task automatic user_mode_access();
		drive_addrs(1'b1, 32'h8000_1000, 32'hC000_2000, 8'h21);
		bit_check("inst_illegal", inst_illegal, 1'b1);
		bit_check("data_illegal", data_illegal, 1'b1);
		drive_addrs(1'b1, 32'h0024_6ABC, 32'h0024_7ABC, 8'h21);
		bit_check("inst_illegal", inst_illegal, 1'b0);
		bit_check("data_illegal", data_illegal, 1'b0);
		drive_addrs(1'b0, 32'h8000_1000, 32'hC000_2000, 8'h21);
		bit_check("inst_illegal", inst_illegal, 1'b0);
		bit_check("data_illegal", data_illegal, 1'b0);
	endtask

	initial
	begin
		void'($urandom(32'h5bef));
		checks        = 0;
		errors        = 0;
		rst           = 1'b1;
		asid          = 8'h00;
		is_user_mode  = 1'b0;
		inst_vaddr    = '0;
		data_vaddr    = '0;
		tlbrw_index   = '0;
		tlbrw_we      = 1'b0;
		tlbrw_wdata   = '0;
		tlbp_entry_hi = '0;
		repeat (3) @(posedge clk);
		rst <= 1'b0;

		entry_readback();
		unmapped_segments();
		mapped_hits();
		miss_and_invalid();
		probe_lookup();
		user_mode_access();

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

`default_nettype wire

//--- tlb.sv
`timescale 1ns/1ns
`default_nettype none

module tlb(
	input  logic                 clk,
	input  logic                 rst,
	input  logic [7:0]           asid,
	input  mmu_pkg::virt_t       inst_vaddr,
	input  mmu_pkg::virt_t       data_vaddr,
	output mmu_pkg::tlb_result_t inst_result,
	output mmu_pkg::tlb_result_t data_result,

	input  mmu_pkg::tlb_index_t  tlbrw_index,
	input  logic                 tlbrw_we,
	input  mmu_pkg::tlb_entry_t  tlbrw_wdata,
	output mmu_pkg::tlb_entry_t  tlbrw_rdata,

	input  mmu_pkg::uint32_t     tlbp_entry_hi,
	output mmu_pkg::uint32_t     tlbp_index
);
	import mmu_pkg::*;

	tlb_req_if   req();
	tlb_match_if match();

	tlb_request_decode decode_inst(
		.tlbrw_index,
		.tlbrw_we,
		.tlbrw_wdata,
		.asid,
		.inst_vaddr,
		.data_vaddr,
		.tlbp_entry_hi,
		.req(req.dec)
	);

	for (genvar i = 0; i < TLB_ENTRIES; i++)
	begin: gen_entry
		tlb_entry #(.IDX(i)) entry_inst(
			.clk,
			.rst,
			.req(req.ent),
			.match(match.ent)
		);
	end

	tlb_select select_inst(
		.match(match.sel),
		.inst_odd(req.inst_odd),
		.data_odd(req.data_odd),
		.inst_vaddr,
		.data_vaddr,
		.tlbrw_index,
		.inst_result,
		.data_result,
		.tlbp_index,
		.tlbrw_rdata
	);

endmodule

`default_nettype wire

//--- tlb_entry.sv
`timescale 1ns/1ns
`default_nettype none

module tlb_entry #(
	parameter int IDX = 0
)(
	input  logic    clk,
	input  logic    rst,
	tlb_req_if.ent  req,
	tlb_match_if.ent match
);
	import mmu_pkg::*;

	tlb_entry_t entry_q;

	// --------------------------------------------------
	// storage.
	// --------------------------------------------------
	always_ff @(posedge clk)
	begin
		if (rst)
			entry_q <= '0;
		else if (req.we[IDX])
			entry_q <= req.wdata;
	end

	// --------------------------------------------------
	// comparators.
	// --------------------------------------------------
	function automatic logic key_hit(
		input logic [18:0] vpn2,
		input logic [7:0]  key_asid
	);
		// global pages ignore the asid.
		return (entry_q.vpn2 == vpn2) && (entry_q.g || entry_q.asid == key_asid);
	endfunction

	assign match.inst_hit[IDX]  = key_hit(req.inst_vpn2, req.asid);
	assign match.data_hit[IDX]  = key_hit(req.data_vpn2, req.asid);
	assign match.probe_hit[IDX] = key_hit(req.probe_vpn2, req.probe_asid);
	assign match.entries[IDX]   = entry_q;

endmodule

`default_nettype wire

//--- tlb_lookup_if.sv
`timescale 1ns/1ns
`default_nettype none

// request broadcast from the decoder to every entry.
interface tlb_req_if;
	import mmu_pkg::*;

	logic [TLB_ENTRIES-1:0] we;
	tlb_entry_t             wdata;
	logic [7:0]             asid;
	logic [18:0]            inst_vpn2;
	logic                   inst_odd;
	logic [18:0]            data_vpn2;
	logic                   data_odd;
	logic [18:0]            probe_vpn2;
	logic [7:0]             probe_asid;

	modport dec(
		output we, wdata, asid, inst_vpn2, inst_odd,
		output data_vpn2, data_odd, probe_vpn2, probe_asid
	);

	modport ent(
		input we, wdata, asid, inst_vpn2, data_vpn2, probe_vpn2, probe_asid
	);
endinterface

// each entry owns bit IDX of the hit vectors and slot IDX of entries.
interface tlb_match_if;
	import mmu_pkg::*;

	logic [TLB_ENTRIES-1:0]             inst_hit;
	logic [TLB_ENTRIES-1:0]             data_hit;
	logic [TLB_ENTRIES-1:0]             probe_hit;
	tlb_entry_t [TLB_ENTRIES-1:0]       entries;

	modport ent(output inst_hit, data_hit, probe_hit, entries);
	modport sel(input inst_hit, data_hit, probe_hit, entries);
endinterface

`default_nettype wire

//--- tlb_request_decode.sv
`timescale 1ns/1ns
`default_nettype none

module tlb_request_decode(
	input  mmu_pkg::tlb_index_t tlbrw_index,
	input  logic                tlbrw_we,
	input  mmu_pkg::tlb_entry_t tlbrw_wdata,
	input  logic [7:0]          asid,
	input  mmu_pkg::virt_t      inst_vaddr,
	input  mmu_pkg::virt_t      data_vaddr,
	input  mmu_pkg::uint32_t    tlbp_entry_hi,
	tlb_req_if.dec              req
);
	import mmu_pkg::*;

	// one-hot write enable.
	always_comb
	begin
		req.we = '0;
		if (tlbrw_we)
			req.we[tlbrw_index] = 1'b1;
	end

	assign req.wdata = tlbrw_wdata;
	assign req.asid  = asid;

	// bit 12 picks the odd page of the pair.
	assign req.inst_vpn2 = inst_vaddr[31:13];
	assign req.inst_odd  = inst_vaddr[12];
	assign req.data_vpn2 = data_vaddr[31:13];
	assign req.data_odd  = data_vaddr[12];

	// entry_hi layout: vpn2 high, asid in the low byte.
	assign req.probe_vpn2 = tlbp_entry_hi[31:13];
	assign req.probe_asid = tlbp_entry_hi[7:0];

endmodule

`default_nettype wire

//--- tlb_select.sv
`timescale 1ns/1ns
`default_nettype none

module tlb_select(
	tlb_match_if.sel              match,
	input  logic                  inst_odd,
	input  logic                  data_odd,
	input  mmu_pkg::virt_t        inst_vaddr,
	input  mmu_pkg::virt_t        data_vaddr,
	input  mmu_pkg::tlb_index_t   tlbrw_index,
	output mmu_pkg::tlb_result_t  inst_result,
	output mmu_pkg::tlb_result_t  data_result,
	output mmu_pkg::uint32_t      tlbp_index,
	output mmu_pkg::tlb_entry_t   tlbrw_rdata
);
	import mmu_pkg::*;

	logic       probe_found;
	tlb_index_t probe_idx;

	// lowest index wins, so scan downward and keep the last hit.
	function automatic void first_hit(
		input  logic [TLB_ENTRIES-1:0] hit,
		output logic                   found,
		output tlb_index_t             idx
	);
		found = 1'b0;
		idx   = '0;
		for (int i = TLB_ENTRIES - 1; i >= 0; i--)
		begin
			if (hit[i])
			begin
				found = 1'b1;
				idx   = tlb_index_t'(i);
			end
		end
	endfunction

	function automatic tlb_result_t page_lookup(
		input logic [TLB_ENTRIES-1:0]       hit,
		input logic                         odd,
		input virt_t                        vaddr,
		input tlb_entry_t [TLB_ENTRIES-1:0] entries
	);
		tlb_result_t res;
		tlb_entry_t  ent;
		logic        found;
		tlb_index_t  idx;
		res = '0;
		first_hit(hit, found, idx);
		ent = entries[idx];
		res.miss = ~found;
		if (found)
		begin
			res.phy_addr = {odd ? ent.pfn1 : ent.pfn0, vaddr[11:0]};
			res.valid    = odd ? ent.v1 : ent.v0;
			res.dirty    = odd ? ent.d1 : ent.d0;
		end
		return res;
	endfunction

	assign inst_result = page_lookup(match.inst_hit, inst_odd, inst_vaddr, match.entries);
	assign data_result = page_lookup(match.data_hit, data_odd, data_vaddr, match.entries);

	always_comb
		first_hit(match.probe_hit, probe_found, probe_idx);

	// bit 31 flags a failed probe.
	assign tlbp_index  = probe_found ? uint32_t'(probe_idx) : 32'h8000_0000;
	assign tlbrw_rdata = match.entries[tlbrw_index];

endmodule

`default_nettype wire
